// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

   localparam int xlen       = 32;   // data and instruction width
   localparam int reg_addr_w = 5;    // register index width
   localparam int op_w       = 7;    // opcode field
   localparam int f3_w       = 3;    // funct3 field
   localparam int f7_w       = 7;    // funct7 field

   localparam logic [op_w-1:0] op_imm    = 7'b0010011;  // addi
   localparam logic [op_w-1:0] op_reg    = 7'b0110011;  // add and xor
   localparam logic [op_w-1:0] op_load   = 7'b0000011;  // lw
   localparam logic [op_w-1:0] op_store  = 7'b0100011;  // sw
   localparam logic [op_w-1:0] op_branch = 7'b1100011;  // beq and bge
   localparam logic [op_w-1:0] op_matr   = 7'b0001011;  // custom-0 matrix product

   localparam logic [f3_w-1:0] f3_add  = 3'b000;
   localparam logic [f3_w-1:0] f3_xor  = 3'b100;
   localparam logic [f3_w-1:0] f3_beq  = 3'b000;
   localparam logic [f3_w-1:0] f3_bge  = 3'b101;  // signed compare
   localparam logic [f3_w-1:0] f3_word = 3'b010;  // lw and sw width

   localparam logic [f7_w-1:0] f7_base = 7'b0000000;  // plain add and xor

   localparam logic [reg_addr_w-1:0] reg_sp = 5'd2;   // x2 holds the stack pointer

endpackage

// ==== hw/soc_cfg_pkg.sv ====
package soc_cfg_pkg;

   localparam int dmem_words  = 64;   // data ram depth in words
   localparam int dmem_addr_w = 6;    // word address into data ram
   localparam int imem_words  = 64;   // program rom depth in words

   localparam int stack_top   = 256;  // sp after reset, byte address

   localparam int mat_n       = 3;    // square matrix size
   localparam int mat_idx_w   = 2;    // row and column counter width

   localparam int mat_a_base  = 0;    // byte addresses of the operands
   localparam int mat_b_base  = 36;
   localparam int mat_c_base  = 72;   // result, sorted in place afterwards

endpackage

// ==== hw/mem_bus_if.sv ====
interface mem_bus_if;

   logic                         req_valid;  // master has a request up
   logic                         req_ready;  // slave can take it this cycle
   logic                         we;         // write when high
   logic [rv_isa_pkg::xlen-1:0]  addr;       // byte address
   logic [rv_isa_pkg::xlen-1:0]  wdata;
   logic                         rsp_valid;  // read data one cycle after accept
   logic [rv_isa_pkg::xlen-1:0]  rdata;

   modport master
   (
      output req_valid,
      output we,
      output addr,
      output wdata,
      input  req_ready,
      input  rsp_valid,
      input  rdata
   );

   modport slave
   (
      input  req_valid,
      input  we,
      input  addr,
      input  wdata,
      output req_ready,
      output rsp_valid,
      output rdata
   );

endinterface

// ==== hw/inst_mem.sv ====
module inst_mem
(
   input  logic          clk_50,
   input  logic [31:0]   addr,
   output logic [31:0]   inst
);

   logic [29:0] word;   // word index of the byte address

   assign word = addr[31:2];

   always_ff @(posedge clk_50)
   begin
      if (word >= soc_cfg_pkg::imem_words)
         inst <= 32'h0;   // past the rom reads as halt
      else
      begin
         case (word)
            0:  inst <= 32'h00000013;   // nop
            1:  inst <= 32'h00000013;   // nop
            2:  inst <= 32'h00000013;   // nop
            3:  inst <= 32'h00000013;   // nop
            4:  inst <= 32'h00000013;   // nop
            5:  inst <= 32'hff810113;   // sp -= 8
            6:  inst <= 32'h01412223;   // push s4 at sp+4
            7:  inst <= 32'h01312023;   // push s3 at sp+0
            8:  inst <= 32'h00400993;   // s3 = 4, pass counter in bytes
            9:  inst <= 32'h00000a13;   // s4 = 0, first pair offset
            10: inst <= 32'h00000793;   // a5 = A base
            11: inst <= 32'h02400813;   // a6 = B base
            12: inst <= 32'h04800893;   // a7 = C base
            13: inst <= 32'h0107888b;   // matr a7, a5, a6
            14: inst <= 32'h00000513;   // outer loop head, a0 = 0
            15: inst <= 32'h02400613;   // a2 = 36, nine words
            16: inst <= 32'h04800293;   // t0 walks C from its base
            17: inst <= 32'h04c9d863;   // s3 >= a2 ends the sort
            18: inst <= 32'h00000e33;   // t3 = 0
            19: inst <= 32'hffc60e13;   // t3 = a2 - 4, last pair
            20: inst <= 32'h000a0f13;   // t5 = s4
            21: inst <= 32'h03cf5863;   // inner loop head, t5 >= t3 ends the pass
            22: inst <= 32'h0002a503;   // a0 = C[j]
            23: inst <= 32'h0042a583;   // a1 = C[j+1]
            24: inst <= 32'h00428293;   // t0 += 4
            25: inst <= 32'h02a5d463;   // already ordered, skip the swap
            26: inst <= 32'h00050f93;   // t6 = a0
            27: inst <= 32'h00058513;   // a0 = a1
            28: inst <= 32'h000f8593;   // a1 = t6
            29: inst <= 32'hfea2ae23;   // store lower word back
            30: inst <= 32'h00b2a023;   // store upper word back
            31: inst <= 32'h004f0f13;   // t5 += 4
            32: inst <= 32'hfc000ae3;   // back to inner loop head
            33: inst <= 32'h00498993;   // pass done, s3 += 4
            34: inst <= 32'hfa0008e3;   // back to outer loop head
            35: inst <= 32'h004f0f13;   // no swap path, t5 += 4
            36: inst <= 32'hfc0002e3;   // back to inner loop head
            37: inst <= 32'h00012983;   // pop s3
            38: inst <= 32'h00412a03;   // pop s4
            39: inst <= 32'h00810113;   // sp += 8
            40: inst <= 32'h00a54533;   // a0 = 0 via xor
            default: inst <= 32'h0;     // halt
         endcase
      end
   end

endmodule

// ==== hw/data_mem.sv ====
module data_mem
(
   input  logic                                 clk_50,
   mem_bus_if.slave                             bus,
   input  logic                                 ld_valid,
   input  logic [soc_cfg_pkg::dmem_addr_w-1:0]  ld_addr,
   input  logic [rv_isa_pkg::xlen-1:0]          ld_data,
   input  logic [soc_cfg_pkg::dmem_addr_w-1:0]  dbg_addr,
   output logic [rv_isa_pkg::xlen-1:0]          dbg_data
);

   logic [rv_isa_pkg::xlen-1:0]          mem [soc_cfg_pkg::dmem_words];
   logic [soc_cfg_pkg::dmem_addr_w-1:0]  bus_word;   // word index of bus address
   logic                                 accept;     // request taken this edge

   assign bus_word      = bus.addr[soc_cfg_pkg::dmem_addr_w+1:2];
   assign bus.req_ready = !ld_valid;   // load port wins, bus master stalls
   assign accept        = bus.req_valid && bus.req_ready;

   always_ff @(posedge clk_50)
   begin
      if (ld_valid)
         mem[ld_addr] <= ld_data;      // external preload
      else if (accept && bus.we)
         mem[bus_word] <= bus.wdata;
   end

   always_ff @(posedge clk_50)
   begin
      bus.rsp_valid <= accept && !bus.we;   // reads answer exactly one cycle later
      if (accept && !bus.we)
         bus.rdata <= mem[bus_word];
      dbg_data <= mem[dbg_addr];            // registered debug read
   end

endmodule

// ==== hw/reg_file.sv ====
module reg_file
(
   input  logic                                clk_50,
   input  logic                                rst_n,
   input  logic [rv_isa_pkg::reg_addr_w-1:0]   rs1_addr,
   input  logic [rv_isa_pkg::reg_addr_w-1:0]   rs2_addr,
   output logic [rv_isa_pkg::xlen-1:0]         rs1_data,
   output logic [rv_isa_pkg::xlen-1:0]         rs2_data,
   input  logic                                wr_en,
   input  logic [rv_isa_pkg::reg_addr_w-1:0]   rd_addr,
   input  logic [rv_isa_pkg::xlen-1:0]         rd_data
);

   logic [rv_isa_pkg::xlen-1:0] regs [32];

   always_ff @(posedge clk_50)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < 32; r++)
            regs[r] <= (r == rv_isa_pkg::reg_sp) ? soc_cfg_pkg::stack_top : 0;
      end
      else if (wr_en && rd_addr != '0)   // x0 stays zero
         regs[rd_addr] <= rd_data;
   end

   // async read, operands settle within the execute cycle
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/matrix_unit.sv ====
module matrix_unit
(
   input  logic                          clk_50,
   input  logic                          rst_n,
   input  logic                          start,    // one cycle pulse
   input  logic [rv_isa_pkg::xlen-1:0]   a_base,
   input  logic [rv_isa_pkg::xlen-1:0]   b_base,
   input  logic [rv_isa_pkg::xlen-1:0]   c_base,
   output logic                          done,     // one cycle after the last write
   mem_bus_if.master                     bus
);

   typedef enum logic [2:0] {m_idle, m_req_a, m_wait_a, m_req_b, m_wait_b, m_write, m_done}
      mstate_t;

   mstate_t                                 state;
   logic [soc_cfg_pkg::mat_idx_w-1:0]       i, j, k;        // row, column, term
   logic [rv_isa_pkg::xlen-1:0]             a_r, b_r, c_r;  // bases held for the run
   logic signed [rv_isa_pkg::xlen-1:0]      a_val;          // A[i][k] waiting for B[k][j]
   logic signed [rv_isa_pkg::xlen-1:0]      acc;            // running dot product
   logic [rv_isa_pkg::xlen-1:0]             a_addr, b_addr, c_addr;
   logic                                    last_k, last_j, last_i;

   assign last_k = (k == soc_cfg_pkg::mat_n - 1);
   assign last_j = (j == soc_cfg_pkg::mat_n - 1);
   assign last_i = (i == soc_cfg_pkg::mat_n - 1);

   // row major, four bytes per word
   assign a_addr = a_r + ((i * soc_cfg_pkg::mat_n + k) << 2);
   assign b_addr = b_r + ((k * soc_cfg_pkg::mat_n + j) << 2);
   assign c_addr = c_r + ((i * soc_cfg_pkg::mat_n + j) << 2);

   assign bus.req_valid = (state == m_req_a) || (state == m_req_b) || (state == m_write);
   assign bus.we        = (state == m_write);
   assign bus.addr      = (state == m_req_a) ? a_addr : (state == m_req_b) ? b_addr : c_addr;
   assign bus.wdata     = acc;
   assign done          = (state == m_done);

   always_ff @(posedge clk_50)
   begin
      if (!rst_n)
      begin
         state <= m_idle;
         i     <= '0;
         j     <= '0;
         k     <= '0;
      end
      else
      begin
         case (state)
            m_idle:
               if (start)
               begin
                  a_r   <= a_base;
                  b_r   <= b_base;
                  c_r   <= c_base;
                  i     <= '0;
                  j     <= '0;
                  k     <= '0;
                  acc   <= '0;
                  state <= m_req_a;
               end
            m_req_a:
               if (bus.req_ready)
                  state <= m_wait_a;     // hold address until taken
            m_wait_a:
               if (bus.rsp_valid)
               begin
                  a_val <= $signed(bus.rdata);
                  state <= m_req_b;
               end
            m_req_b:
               if (bus.req_ready)
                  state <= m_wait_b;
            m_wait_b:
               if (bus.rsp_valid)
               begin
                  acc <= acc + a_val * $signed(bus.rdata);   // low 32 bits kept
                  k   <= last_k ? '0 : k + 1'b1;
                  state <= last_k ? m_write : m_req_a;
               end
            m_write:
               if (bus.req_ready)
               begin
                  acc <= '0;
                  j   <= last_j ? '0 : j + 1'b1;
                  if (last_j)
                     i <= last_i ? '0 : i + 1'b1;
                  state <= (last_j && last_i) ? m_done : m_req_a;   // ninth write ends it
               end
            m_done:
               state <= m_idle;
            default:
               state <= m_idle;
         endcase
      end
   end

endmodule

// ==== hw/core_ctrl.sv ====
module core_ctrl
(
   input  logic                          clk_50,
   input  logic                          rst_n,
   input  logic                          start,
   output logic                          halted,
   output logic [rv_isa_pkg::xlen-1:0]   imem_addr,
   input  logic [rv_isa_pkg::xlen-1:0]   imem_inst,
   mem_bus_if.master                     bus
);

   typedef enum logic [2:0] {s_idle, s_fetch, s_wait, s_exec, s_mem_req, s_mem_wait,
                             s_matr, s_halt} state_t;

   state_t                                 state;
   logic [rv_isa_pkg::xlen-1:0]            pc;
   logic [rv_isa_pkg::xlen-1:0]            ir;        // instruction under execution
   logic [rv_isa_pkg::xlen-1:0]            c_base_r;  // rd value for matr, read in wait
   logic [rv_isa_pkg::op_w-1:0]            opcode;
   logic [rv_isa_pkg::f3_w-1:0]            f3;
   logic [rv_isa_pkg::f7_w-1:0]            f7;
   logic [rv_isa_pkg::reg_addr_w-1:0]      rs1_addr;
   logic [rv_isa_pkg::xlen-1:0]            rs1_data, rs2_data, rd_data;
   logic [rv_isa_pkg::xlen-1:0]            imm_i, imm_s, imm_b, alu_res, ls_addr;
   logic                                   is_addi, is_add, is_xor, is_lw, is_sw;
   logic                                   is_beq, is_bge, is_matr, is_alu, taken;
   logic                                   wr_en, mu_start, mu_done, mu_owns;

   mem_bus_if mu_bus ();   // matrix unit side of the bus mux

   assign opcode = ir[6:0];
   assign f3     = ir[14:12];
   assign f7     = ir[31:25];
   assign imm_i  = {{20{ir[31]}}, ir[31:20]};
   assign imm_s  = {{20{ir[31]}}, ir[31:25], ir[11:7]};
   assign imm_b  = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

   assign is_addi = (opcode == rv_isa_pkg::op_imm) && (f3 == rv_isa_pkg::f3_add);
   assign is_add  = (opcode == rv_isa_pkg::op_reg) && (f7 == rv_isa_pkg::f7_base)
                    && (f3 == rv_isa_pkg::f3_add);
   assign is_xor  = (opcode == rv_isa_pkg::op_reg) && (f7 == rv_isa_pkg::f7_base)
                    && (f3 == rv_isa_pkg::f3_xor);
   assign is_lw   = (opcode == rv_isa_pkg::op_load) && (f3 == rv_isa_pkg::f3_word);
   assign is_sw   = (opcode == rv_isa_pkg::op_store) && (f3 == rv_isa_pkg::f3_word);
   assign is_beq  = (opcode == rv_isa_pkg::op_branch) && (f3 == rv_isa_pkg::f3_beq);
   assign is_bge  = (opcode == rv_isa_pkg::op_branch) && (f3 == rv_isa_pkg::f3_bge);
   assign is_matr = (opcode == rv_isa_pkg::op_matr);
   assign is_alu  = is_addi || is_add || is_xor;

   assign alu_res = is_xor ? (rs1_data ^ rs2_data) : rs1_data + (is_add ? rs2_data : imm_i);
   assign ls_addr = rs1_data + (is_sw ? imm_s : imm_i);
   assign taken   = (is_beq && rs1_data == rs2_data)
                    || (is_bge && $signed(rs1_data) >= $signed(rs2_data));

   // port 1 reads matr's rd while the word is still on the rom output
   assign rs1_addr = (state == s_wait) ? imem_inst[11:7] : ir[19:15];
   assign wr_en    = ((state == s_exec) && is_alu) || ((state == s_mem_wait) && bus.rsp_valid);
   assign rd_data  = (state == s_mem_wait) ? bus.rdata : alu_res;

   assign imem_addr = pc;
   assign halted    = (state == s_halt);
   assign mu_start  = (state == s_exec) && is_matr;

   // matrix unit owns the bus only while the core waits on matr
   assign mu_owns          = (state == s_matr);
   assign bus.req_valid    = mu_owns ? mu_bus.req_valid : (state == s_mem_req);
   assign bus.we           = mu_owns ? mu_bus.we : is_sw;
   assign bus.addr         = mu_owns ? mu_bus.addr : ls_addr;
   assign bus.wdata        = mu_owns ? mu_bus.wdata : rs2_data;
   assign mu_bus.req_ready = mu_owns && bus.req_ready;
   assign mu_bus.rsp_valid = mu_owns && bus.rsp_valid;
   assign mu_bus.rdata     = bus.rdata;

   reg_file u_reg_file
   (
      .clk_50   (clk_50),
      .rst_n    (rst_n),
      .rs1_addr (rs1_addr),
      .rs2_addr (ir[24:20]),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wr_en    (wr_en),
      .rd_addr  (ir[11:7]),
      .rd_data  (rd_data)
   );

   matrix_unit u_matrix_unit
   (
      .clk_50 (clk_50),
      .rst_n  (rst_n),
      .start  (mu_start),
      .a_base (rs1_data),
      .b_base (rs2_data),
      .c_base (c_base_r),
      .done   (mu_done),
      .bus    (mu_bus.master)
   );

   always_ff @(posedge clk_50)
   begin
      if (state == s_wait)
      begin
         ir       <= imem_inst;
         c_base_r <= rs1_data;
      end
   end

   always_ff @(posedge clk_50)
   begin
      if (!rst_n)
      begin
         state <= s_idle;
         pc    <= '0;
      end
      else
      begin
         case (state)
            s_idle:
               if (start)
                  state <= s_fetch;
            s_fetch:
               state <= s_wait;                                  // rom registers pc
            s_wait:
               state <= (imem_inst == '0) ? s_halt : s_exec;     // zero word halts
            s_exec:
            begin
               if (is_lw || is_sw)
                  state <= s_mem_req;
               else if (is_matr)
                  state <= s_matr;
               else if (is_alu || is_beq || is_bge)
               begin
                  pc    <= taken ? pc + imm_b : pc + 32'd4;
                  state <= s_fetch;
               end
               else
                  state <= s_halt;                               // unsupported word
            end
            s_mem_req:
               if (bus.req_ready)
               begin
                  if (is_sw)
                     pc <= pc + 32'd4;
                  state <= is_sw ? s_fetch : s_mem_wait;         // stores get no response
               end
            s_mem_wait:
               if (bus.rsp_valid)
               begin
                  pc    <= pc + 32'd4;
                  state <= s_fetch;
               end
            s_matr:
               if (mu_done)
               begin
                  pc    <= pc + 32'd4;
                  state <= s_fetch;
               end
            default:
               state <= s_halt;                                  // held until reset
         endcase
      end
   end

endmodule

// ==== hw/soc_top.sv ====
module soc_top
(
   input  logic                                 clk_50,
   input  logic                                 rst_n,
   input  logic                                 start,
   output logic                                 halted,
   input  logic                                 ld_valid,
   input  logic [soc_cfg_pkg::dmem_addr_w-1:0]  ld_addr,    // word address
   input  logic [rv_isa_pkg::xlen-1:0]          ld_data,
   input  logic [soc_cfg_pkg::dmem_addr_w-1:0]  dbg_addr,   // word address
   output logic [rv_isa_pkg::xlen-1:0]          dbg_data
);

   logic [rv_isa_pkg::xlen-1:0] imem_addr;
   logic [rv_isa_pkg::xlen-1:0] imem_inst;

   mem_bus_if dbus ();   // core to data ram

   core_ctrl u_core_ctrl
   (
      .clk_50    (clk_50),
      .rst_n     (rst_n),
      .start     (start),
      .halted    (halted),
      .imem_addr (imem_addr),
      .imem_inst (imem_inst),
      .bus       (dbus.master)
   );

   inst_mem u_inst_mem
   (
      .clk_50 (clk_50),
      .addr   (imem_addr),
      .inst   (imem_inst)
   );

   data_mem u_data_mem
   (
      .clk_50   (clk_50),
      .bus      (dbus.slave),
      .ld_valid (ld_valid),
      .ld_addr  (ld_addr),
      .ld_data  (ld_data),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data)
   );

endmodule

// ==== test/tb_soc.sv ====
module tb_soc;

   localparam int n_cases    = 4;
   localparam int n_elem     = soc_cfg_pkg::mat_n * soc_cfg_pkg::mat_n;
   localparam int a_word     = soc_cfg_pkg::mat_a_base / 4;   // word index of A
   localparam int b_word     = soc_cfg_pkg::mat_b_base / 4;
   localparam int c_word     = soc_cfg_pkg::mat_c_base / 4;
   localparam int sp_word    = soc_cfg_pkg::stack_top / 4;    // one past the stack frame
   localparam int halt_limit = 20000;                         // cycles per program run

   logic                                 clk_50;
   logic                                 rst_n;
   logic                                 start;
   logic                                 halted;
   logic                                 ld_valid;
   logic [soc_cfg_pkg::dmem_addr_w-1:0]  ld_addr;
   logic [rv_isa_pkg::xlen-1:0]          ld_data;
   logic [soc_cfg_pkg::dmem_addr_w-1:0]  dbg_addr;
   logic [rv_isa_pkg::xlen-1:0]          dbg_data;

   int     tbl_a [n_cases][n_elem];   // A per case in row major order
   int     tbl_b [n_cases][n_elem];   // B per case
   int     exp_c [n_cases][n_elem];   // product sorted ascending
   int     checks;
   int     mismatches;
   int     timeouts;
   integer seed;

   soc_top dut_i
   (
      .clk_50   (clk_50),
      .rst_n    (rst_n),
      .start    (start),
      .halted   (halted),
      .ld_valid (ld_valid),
      .ld_addr  (ld_addr),
      .ld_data  (ld_data),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data)
   );

   initial
   begin
      clk_50 = 1'b0;
      forever #10 clk_50 = ~clk_50;   // period 20
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         mismatches++;
         $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name,
                  $signed(expected), $signed(actual));
      end
   endtask

   task automatic build_table();
      tbl_a[0] = '{1, 0, 0, 0, 1, 0, 0, 0, 1};            // identity
      tbl_b[0] = '{5, -3, 7, 2, 9, -1, 0, 4, -8};
      tbl_a[1] = '{-1, -2, -3, -4, -5, -6, -7, -8, -9};   // all negative
      tbl_b[1] = '{-9, -8, -7, -6, -5, -4, -3, -2, -1};
      tbl_a[2] = '{0, 3, -2, 1, 0, 4, -5, 6, 0};          // mix with zeros
      tbl_b[2] = '{2, 0, -1, 0, -3, 5, 7, 1, 0};
      seed = 32'hbc80;
      for (int e = 0; e < n_elem; e++)
      begin
         tbl_a[3][e] = $random(seed) % 101;   // within +-100
         tbl_b[3][e] = $random(seed) % 101;
      end
   endtask

   // reference model of C = A * B followed by an ascending signed bubble sort
   task automatic build_expected(input int c);
      int sum;
      int tmp;
      for (int i = 0; i < soc_cfg_pkg::mat_n; i++)
      begin
         for (int j = 0; j < soc_cfg_pkg::mat_n; j++)
         begin
            sum = 0;
            for (int k = 0; k < soc_cfg_pkg::mat_n; k++)
               sum += tbl_a[c][i * soc_cfg_pkg::mat_n + k] * tbl_b[c][k * soc_cfg_pkg::mat_n + j];
            exp_c[c][i * soc_cfg_pkg::mat_n + j] = sum;   // wraps like 32 bit hw
         end
      end
      for (int p = 0; p < n_elem - 1; p++)
      begin
         for (int e = 0; e < n_elem - 1 - p; e++)
         begin
            if (exp_c[c][e] > exp_c[c][e + 1])
            begin
               tmp             = exp_c[c][e];
               exp_c[c][e]     = exp_c[c][e + 1];
               exp_c[c][e + 1] = tmp;
            end
         end
      end
   endtask

   task automatic apply_reset();
      @(posedge clk_50);
      rst_n    <= 1'b0;
      start    <= 1'b0;
      ld_valid <= 1'b0;
      repeat (16) @(posedge clk_50);   // 16 edges with reset low
      rst_n <= 1'b1;
   endtask

   task automatic check_idle();
      repeat (20)
      begin
         @(negedge clk_50);
         check_value("halted before start", 32'd0, 32'(halted));
      end
   endtask

   task automatic load_memory(input int c);
      int value;
      for (int w = 0; w < soc_cfg_pkg::dmem_words; w++)
      begin
         if (w >= a_word && w < a_word + n_elem)
            value = tbl_a[c][w - a_word];
         else if (w >= b_word && w < b_word + n_elem)
            value = tbl_b[c][w - b_word];
         else if (w >= sp_word - 2)
            value = 32'h5a5a0000 ^ w;  // stack slots hold a pattern until the pushes land
         else
            value = 0;                 // C and the unused words start cleared
         @(posedge clk_50);
         ld_valid <= 1'b1;
         ld_addr  <= w[soc_cfg_pkg::dmem_addr_w-1:0];
         ld_data  <= value;
      end
      @(posedge clk_50);
      ld_valid <= 1'b0;
   endtask

   task automatic pulse_start();
      @(posedge clk_50);
      start <= 1'b1;
      @(posedge clk_50);
      start <= 1'b0;
   endtask

   task automatic wait_halted(input int c);
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk_50);   // halted is settled mid cycle
         cycles++;
      end
      while (halted !== 1'b1 && cycles < halt_limit);
      if (halted !== 1'b1)
      begin
         timeouts++;
         $display("TIMEOUT: case %0d, the core did not halt within %0d cycles", c, halt_limit);
      end
   endtask

   task automatic read_word(input int w, output logic [31:0] data);
      @(posedge clk_50);
      dbg_addr <= w[soc_cfg_pkg::dmem_addr_w-1:0];
      @(posedge clk_50);                // debug port registers the word here
      @(negedge clk_50);
      data = dbg_data;
   endtask

   task automatic check_memory(input int c);
      logic [31:0] data;
      for (int e = 0; e < n_elem; e++)
      begin
         read_word(c_word + e, data);
         check_value($sformatf("case %0d c[%0d]", c, e), exp_c[c][e], data);
      end
      for (int e = 0; e < n_elem; e++)
      begin
         read_word(a_word + e, data);   // operands must survive the run
         check_value($sformatf("case %0d a[%0d]", c, e), tbl_a[c][e], data);
         read_word(b_word + e, data);
         check_value($sformatf("case %0d b[%0d]", c, e), tbl_b[c][e], data);
      end
      read_word(sp_word - 2, data);     // saved s3
      check_value("stack slot s3", 32'd0, data);
      read_word(sp_word - 1, data);     // saved s4
      check_value("stack slot s4", 32'd0, data);
      check_value("halted after run", 32'd1, 32'(halted));   // sticky until reset
   endtask

   initial
   begin
      rst_n      = 1'b0;
      start      = 1'b0;
      ld_valid   = 1'b0;
      ld_addr    = '0;
      ld_data    = '0;
      dbg_addr   = '0;
      checks     = 0;
      mismatches = 0;
      timeouts   = 0;
      build_table();
      for (int c = 0; c < n_cases; c++)
         build_expected(c);
      for (int c = 0; c < n_cases; c++)
      begin
         $display("case %0d", c);
         apply_reset();   // fresh reset per case so nothing carries over
         check_idle();
         load_memory(c);
         pulse_start();
         wait_halted(c);
         check_memory(c);
      end
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== files.f ====
hw/rv_isa_pkg.sv
hw/soc_cfg_pkg.sv
hw/mem_bus_if.sv
hw/inst_mem.sv
hw/data_mem.sv
hw/reg_file.sv
hw/matrix_unit.sv
hw/core_ctrl.sv
hw/soc_top.sv
test/tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then decide by searching the log
verilator --binary --timing --top-module tb_soc -f files.f -o tb_soc > build.log 2>&1 \
   && ./obj_dir/tb_soc > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; cat build.log; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
